/* sources.f */
hdl/mem_pkg.sv
hdl/mem_req_if.sv
hdl/mem_req_queue.sv
hdl/mem_byte_engine.sv
hdl/byte_ram.sv
hdl/mem_access_top.sv
testbench/mem_access_checker.sv
testbench/tb_mem_access.sv

/* testbench/tb_mem_access.sv */
`timescale 1ns/1ps

module tb_mem_access import mem_pkg::*; ();

    localparam int QUEUE_DEPTH     = 16;
    localparam int RAM_ADDR_BITS   = 10;
    localparam int RAM_WORDS       = 2 ** (RAM_ADDR_BITS - 2);
    localparam int CLK_PERIOD      = 8;
    localparam int POOL_WORDS      = 8;
    localparam int BURST_PAIRS     = 24;
    localparam int FLUSH_PAIRS     = 3;
    // Store, load and fetch, four fetches, four pairs and three isolated requests make 18.
    localparam int TOTAL_REQS      = POOL_WORDS + 18 + 2 * (BURST_PAIRS + FLUSH_PAIRS) + 2;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 12 + 200;

    logic  clk;
    logic  rst_n;
    logic  fetch_req;
    addr_t fetch_addr;
    logic  data_req;
    addr_t data_addr;
    word_t data_wdata;
    logic  data_is_store;
    logic  flush;
    logic  stall;
    logic  done;
    logic  done_is_instr;
    word_t done_data;

    int     pending;
    int     errors;
    int     checked;
    int     tb_errors;
    int     stall_cycles;
    integer seed;
    addr_t  pool [POOL_WORDS];

    mem_access_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .RAM_ADDR_BITS(RAM_ADDR_BITS))
        i_mem_access_top (.*);

    mem_access_checker #(.QUEUE_DEPTH(QUEUE_DEPTH), .RAM_ADDR_BITS(RAM_ADDR_BITS))
        i_mem_access_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (stall) stall_cycles++;
    end

    function automatic addr_t pick_addr();
        return pool[$unsigned($random(seed)) % POOL_WORDS];
    endfunction

    function automatic word_t random_word();
        return $random(seed);
    endfunction

    // The next call waits one more edge, so stall already reflects this request.
    task automatic strobe(input logic dreq, input logic dstore, input addr_t daddr,
                          input word_t dwdata, input logic freq, input addr_t faddr);
        @(posedge clk);
        while (stall) @(posedge clk);
        data_req      <= dreq;
        data_is_store <= dstore;
        data_addr     <= daddr;
        data_wdata    <= dwdata;
        fetch_req     <= freq;
        fetch_addr    <= faddr;
        @(posedge clk);
        data_req  <= 1'b0;
        fetch_req <= 1'b0;
    endtask

    task automatic wait_for_drain();
        @(posedge clk);
        while (pending != 0) @(posedge clk);
    endtask

    task automatic check_byte_order(input addr_t a, input word_t w);
        logic [RAM_ADDR_BITS-1:0] idx;
        for (int n = 0; n < 4; n++) begin
            idx = a[RAM_ADDR_BITS-1:0] + n;
            if (i_mem_access_top.i_byte_ram.mem[idx] !== w[8*n +: 8]) begin
                $display("ERROR %0t: RAM byte %0d of %08h is %02h, expected %02h", $time, n, a,
                         i_mem_access_top.i_byte_ram.mem[idx], w[8*n +: 8]);
                tb_errors++;
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run timed out after %0d cycles with %0d requests outstanding.",
                 WATCHDOG_CYCLES, pending);
        $display("TEST FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        addr_t a;
        word_t w;
        int    stall_before;
        seed          = 90720;
        rst_n         = 1'b0;
        fetch_req     = 1'b0;
        fetch_addr    = '0;
        data_req      = 1'b0;
        data_addr     = '0;
        data_wdata    = '0;
        data_is_store = 1'b0;
        flush         = 1'b0;
        tb_errors     = 0;
        stall_cycles  = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < POOL_WORDS; i++) begin     // Every word later read is written first.
            pool[i] = addr_t'(($unsigned($random(seed)) % RAM_WORDS) * 4);
            strobe(1'b1, 1'b1, pool[i], random_word(), 1'b0, '0);
        end
        wait_for_drain();

        a = pool[0];
        w = random_word();
        strobe(1'b1, 1'b1, a, w, 1'b0, '0);
        strobe(1'b1, 1'b0, a, '0, 1'b0, '0);
        strobe(1'b0, 1'b0, '0, '0, 1'b1, a);
        wait_for_drain();
        check_byte_order(a, w);

        repeat (4) strobe(1'b0, 1'b0, '0, '0, 1'b1, pick_addr());
        wait_for_drain();

        repeat (4) strobe(1'b1, $random(seed) & 1, pick_addr(), random_word(), 1'b1, pick_addr());
        wait_for_drain();

        for (int i = 0; i < 3; i++) begin   // The checker times requests seen with the unit idle.
            repeat (3) @(posedge clk);
            strobe(i != 1, 1'b0, pick_addr(), '0, i == 1, pick_addr());
            wait_for_drain();
        end

        stall_before = stall_cycles;
        repeat (BURST_PAIRS) begin
            strobe(1'b1, $random(seed) & 1, pick_addr(), random_word(), 1'b1, pick_addr());
        end
        wait_for_drain();
        @(posedge clk);
        if (stall_cycles == stall_before) begin
            $display("Stall never rose during the request burst.");
            tb_errors++;
        end
        if (stall) begin
            $display("Stall was still high after the queue had drained.");
            tb_errors++;
        end

        repeat (FLUSH_PAIRS) strobe(1'b1, 1'b0, pick_addr(), '0, 1'b1, pick_addr());
        repeat (12) @(posedge clk);     // The flush lands while a load is halfway through its bytes.
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (30) @(posedge clk);     // Any done from a flushed request shows up here.
        strobe(1'b1, 1'b0, pick_addr(), '0, 1'b0, '0);
        strobe(1'b0, 1'b0, '0, '0, 1'b1, pick_addr());
        wait_for_drain();

        repeat (4) @(posedge clk);
        $display("Errors: %0d in checker, %0d in testbench, %0d completions checked.",
                 errors, tb_errors, checked);
        if (errors + tb_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* testbench/mem_access_checker.sv */
`timescale 1ns/1ps

module mem_access_checker import mem_pkg::*; #(
    parameter int QUEUE_DEPTH   = 16,
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  fetch_req,
    input  addr_t fetch_addr,
    input  logic  data_req,
    input  addr_t data_addr,
    input  word_t data_wdata,
    input  logic  data_is_store,
    input  logic  flush,
    input  logic  stall,
    input  logic  done,
    input  logic  done_is_instr,
    input  word_t done_data,
    output int    pending,
    output int    errors,
    output int    checked
);

    localparam int IDLE_LATENCY = 7;    // Edges from the sampling edge to done rising.

    byte_t ref_mem [2 ** RAM_ADDR_BITS];

    word_t exp_word  [$];
    logic  exp_instr [$];
    bit    exp_timed [$];   // Entry was queued with the unit idle.
    int    exp_cycle [$];

    int   cycle;
    int   err_cnt;
    int   chk_cnt;
    logic done_d;

    // Lowest address holds bits 7 to 0.
    function automatic word_t expected_word(input addr_t a);
        word_t w;
        addr_t b;
        for (int n = 0; n < 4; n++) begin
            b = a + addr_t'(n);
            w[8*n +: 8] = ref_mem[b[RAM_ADDR_BITS-1:0]];
        end
        return w;
    endfunction

    task automatic write_ref(input addr_t a, input word_t w);
        addr_t b;
        for (int n = 0; n < 4; n++) begin
            b = a + addr_t'(n);
            ref_mem[b[RAM_ADDR_BITS-1:0]] = w[8*n +: 8];
        end
    endtask

    task automatic push_expected(input logic is_instr, input word_t w);
        exp_timed.push_back(exp_word.size() == 0);
        exp_word.push_back(w);
        exp_instr.push_back(is_instr);
        exp_cycle.push_back(cycle);
    endtask

    task automatic compare_done();
        word_t w;
        logic  i;
        bit    t;
        int    c;
        if (exp_word.size() == 0) begin
            $display("Completion at %0t arrived with no request outstanding.", $time);
            err_cnt++;
        end else begin
            w = exp_word.pop_front();
            i = exp_instr.pop_front();
            t = exp_timed.pop_front();
            c = exp_cycle.pop_front();
            if (done_is_instr !== i || done_data !== w) begin
                $display("ERROR %0t: done is_instr=%0b data=%08h, expected is_instr=%0b data=%08h",
                         $time, done_is_instr, done_data, i, w);
                err_cnt++;
            end
            if (t && (cycle - c - 1) != IDLE_LATENCY) begin
                $display("ERROR %0t: done rose %0d cycles after the request, expected %0d",
                         $time, cycle - c - 1, IDLE_LATENCY);
                err_cnt++;
            end
            chk_cnt++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sampling and comparison
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_word.delete();
            exp_instr.delete();
            exp_timed.delete();
            exp_cycle.delete();
            cycle   = 0;
            done_d  = 1'b0;
        end else begin
            cycle = cycle + 1;
            if (done) begin
                compare_done();     // A word finished before a flush in the same cycle counts.
            end
            if (done && done_d) begin
                $display("Completion strobe at %0t stayed high for more than one cycle.", $time);
                err_cnt++;
            end
            if ((data_req || fetch_req) && stall) begin
                $display("Request at %0t was strobed although stall was high.", $time);
                err_cnt++;
            end
            if (flush) begin
                exp_word.delete();
                exp_instr.delete();
                exp_timed.delete();
                exp_cycle.delete();
            end else begin
                if (data_req && data_is_store) begin
                    write_ref(data_addr, data_wdata);
                    push_expected(1'b0, data_wdata);
                end else if (data_req) begin
                    push_expected(1'b0, expected_word(data_addr));
                end
                if (fetch_req) begin
                    push_expected(1'b1, expected_word(fetch_addr));   // Queued behind data.
                end
            end
            if (exp_word.size() > QUEUE_DEPTH + 1) begin
                $display("More requests outstanding at %0t than queue and engine hold.", $time);
                err_cnt++;
            end
            done_d  = done;
        end
        pending <= exp_word.size();
        errors  <= err_cnt;
        checked <= chk_cnt;
    end

endmodule

/* hdl/mem_access_top.sv */
`timescale 1ns/1ps

module mem_access_top import mem_pkg::*; #(
    parameter int QUEUE_DEPTH   = 16,
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic  clk,
    input  logic  rst_n,
    // Instruction fetch port.
    input  logic  fetch_req,
    input  addr_t fetch_addr,
    // Load/store port.
    input  logic  data_req,
    input  addr_t data_addr,
    input  word_t data_wdata,
    input  logic  data_is_store,
    input  logic  flush,            // Pipeline exception.
    output logic  stall,            // Almost full, requesters hold off.
    output logic  done,
    output logic  done_is_instr,
    output word_t done_data
);

    mem_req_if head_req ();

    addr_t ram_addr;
    logic  ram_we;
    byte_t ram_wdata;
    byte_t ram_rdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Queue, engine, RAM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    mem_req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_mem_req_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .data_req      (data_req),
        .data_addr     (data_addr),
        .data_wdata    (data_wdata),
        .data_is_store (data_is_store),
        .flush         (flush),
        .stall         (stall),
        .req           (head_req)
    );

    mem_byte_engine i_mem_byte_engine (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .req           (head_req),
        .ram_addr      (ram_addr),
        .ram_we        (ram_we),
        .ram_wdata     (ram_wdata),
        .ram_rdata     (ram_rdata),
        .done          (done),
        .done_is_instr (done_is_instr),
        .done_data     (done_data)
    );

    byte_ram #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) i_byte_ram (
        .clk       (clk),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

endmodule

/* hdl/byte_ram.sv */
`timescale 1ns/1ps

module byte_ram import mem_pkg::*; #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic  clk,
    input  addr_t ram_addr,
    input  logic  ram_we,
    input  byte_t ram_wdata,
    output byte_t ram_rdata
);

    localparam int RAM_BYTES = 2 ** RAM_ADDR_BITS;

    typedef logic [RAM_ADDR_BITS-1:0] ram_idx_t;

    byte_t    mem [RAM_BYTES];
    ram_idx_t idx;

    // Upper address bits are ignored, so the array repeats through the address space.
    assign idx = ram_addr[RAM_ADDR_BITS-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Single port, read registered
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[idx] <= ram_wdata;
        end
        ram_rdata <= mem[idx];  // Old contents on a write cycle.
    end

endmodule

/* hdl/mem_byte_engine.sv */
`timescale 1ns/1ps

module mem_byte_engine import mem_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  flush,
    mem_req_if.engine_side req,
    output addr_t ram_addr,
    output logic  ram_we,
    output byte_t ram_wdata,
    input  byte_t ram_rdata,
    output logic  done,
    output logic  done_is_instr,
    output word_t done_data
);

    engine_state_t state;
    logic [1:0]    byte_cnt;

    addr_t cur_addr;
    word_t cur_wdata;
    logic  cur_store;
    logic  cur_instr;

    logic  issue;       // A byte access is being issued this cycle.
    logic  iss_vld;     // RAM port registers hold an access.
    logic  iss_last;    // That access is byte 3.
    logic  rd_vld;      // ram_rdata holds a load byte.
    logic  rd_last;     // That byte is byte 3.
    logic  finish;
    word_t rd_word;     // Load bytes shift in from the top.

    assign req.pop = (state == ENG_IDLE) && req.valid && !flush;
    assign issue   = (state == ENG_ADDR) || (state == ENG_LAST);
    assign finish  = (state == ENG_DONE) && rd_last;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ENG_IDLE;
            byte_cnt <= '0;
        end else if (flush) begin
            state    <= ENG_IDLE;   // The word in progress is dropped without done.
            byte_cnt <= '0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (req.pop) begin
                        state    <= ENG_ADDR;
                        byte_cnt <= '0;
                    end
                end
                ENG_ADDR: begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (byte_cnt == 2'd2) begin
                        state <= ENG_LAST;
                    end
                end
                ENG_LAST: begin
                    byte_cnt <= '0;
                    state    <= ENG_DONE;
                end
                ENG_DONE: begin
                    if (rd_last) begin
                        state <= ENG_IDLE;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RAM side and read return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_we   <= 1'b0;
            iss_vld  <= 1'b0;
            iss_last <= 1'b0;
            rd_vld   <= 1'b0;
            rd_last  <= 1'b0;
            done     <= 1'b0;
        end else if (flush) begin
            ram_we   <= 1'b0;
            iss_vld  <= 1'b0;
            iss_last <= 1'b0;
            rd_vld   <= 1'b0;
            rd_last  <= 1'b0;
            done     <= 1'b0;
        end else begin
            ram_we   <= issue && cur_store;
            iss_vld  <= issue;
            iss_last <= (state == ENG_LAST);
            rd_vld   <= iss_vld && !ram_we;  // RAM answers a read one cycle later.
            rd_last  <= iss_last;
            done     <= finish;
        end
    end

    always_ff @(posedge clk) begin
        if (req.pop) begin
            cur_addr  <= req.addr;
            cur_wdata <= req.wdata;
            cur_store <= req.is_store;
            cur_instr <= req.is_instr;
        end
        if (issue) begin
            // Little-endian: byte n of the word lives at addr + n.
            ram_addr  <= cur_addr + addr_t'(byte_cnt);
            ram_wdata <= cur_wdata[{byte_cnt, 3'b000} +: 8];
        end
        if (rd_vld) begin
            rd_word <= {ram_rdata, rd_word[31:8]};
        end
        if (finish) begin
            done_is_instr <= cur_instr;
            done_data     <= cur_store ? cur_wdata : {ram_rdata, rd_word[31:8]};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A write always belongs to a data store.
    a_no_fetch_write : assert property (
        @(posedge clk) disable iff (!rst_n)
        ram_we |-> !cur_instr
    ) else $error("RAM write issued for an instruction fetch");

    a_done_one_cycle : assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    ) else $error("done stayed high for more than one cycle");

endmodule

/* hdl/mem_req_queue.sv */
`timescale 1ns/1ps

module mem_req_queue import mem_pkg::*; #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  fetch_req,
    input  addr_t fetch_addr,
    input  logic  data_req,
    input  addr_t data_addr,
    input  word_t data_wdata,
    input  logic  data_is_store,
    input  logic  flush,
    output logic  stall,
    mem_req_if.queue_side req
);

    localparam int PTR_W      = $clog2(QUEUE_DEPTH);
    localparam int STALL_FREE = 3;  // Stall below this many free entries.

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Entry storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    addr_t entry_addr  [QUEUE_DEPTH];
    word_t entry_wdata [QUEUE_DEPTH];
    logic  entry_store [QUEUE_DEPTH];
    logic  entry_instr [QUEUE_DEPTH];

    ptr_t       head;
    ptr_t       tail;
    ptr_t       fetch_slot;
    cnt_t       count;
    cnt_t       count_next;
    logic [1:0] n_enq;

    assign n_enq = {1'b0, data_req} + {1'b0, fetch_req};

    // The data request takes the tail slot, so a fetch in the same cycle goes one behind it.
    assign fetch_slot = tail + ptr_t'(data_req);

    assign count_next = count + cnt_t'(n_enq) - cnt_t'(req.pop);

    always_ff @(posedge clk) begin
        if (!flush) begin
            if (data_req) begin
                entry_addr[tail]  <= data_addr;
                entry_wdata[tail] <= data_wdata;
                entry_store[tail] <= data_is_store;
                entry_instr[tail] <= 1'b0;
            end
            if (fetch_req) begin
                entry_addr[fetch_slot]  <= fetch_addr;
                entry_store[fetch_slot] <= 1'b0;   // Fetches never write.
                entry_instr[fetch_slot] <= 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers, occupancy and stall
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            stall <= 1'b0;
        end else if (flush) begin
            // Requests strobed together with flush are lost as well.
            head  <= '0;
            tail  <= '0;
            count <= '0;
            stall <= 1'b0;
        end else begin
            tail  <= tail + ptr_t'(n_enq);
            count <= count_next;
            if (req.pop) begin
                head <= head + 1'b1;
            end
            stall <= (cnt_t'(QUEUE_DEPTH) - count_next) < cnt_t'(STALL_FREE);
        end
    end

    assign req.valid    = (count != '0);
    assign req.addr     = entry_addr[head];
    assign req.wdata    = entry_wdata[head];
    assign req.is_store = entry_store[head];
    assign req.is_instr = entry_instr[head];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Requesters hold off for every cycle in which stall is high.
    a_no_req_after_stall : assert property (
        @(posedge clk) disable iff (!rst_n)
        (fetch_req || data_req) |-> !stall
    ) else $error("request strobed while stall was high");

    // The engine must never take an entry from an empty queue.
    a_no_pop_when_empty : assert property (
        @(posedge clk) disable iff (!rst_n)
        req.pop |-> req.valid
    ) else $error("pop seen while the queue is empty");

endmodule

/* hdl/mem_req_if.sv */
`timescale 1ns/1ps

// Head entry of the request queue as seen by the byte engine.
interface mem_req_if import mem_pkg::*; ();

    logic  valid;       // Queue is not empty.
    addr_t addr;        // Word address of the head entry.
    word_t wdata;       // Store word, only meaningful when is_store is set.
    logic  is_store;
    logic  is_instr;    // Entry came from the fetch port.
    logic  pop;         // One-cycle strobe that removes the head entry.

    modport queue_side (
        output valid,
        output addr,
        output wdata,
        output is_store,
        output is_instr,
        input  pop
    );

    modport engine_side (
        input  valid,
        input  addr,
        input  wdata,
        input  is_store,
        input  is_instr,
        output pop
    );

endinterface

/* hdl/mem_pkg.sv */
package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [31:0] addr_t;    // Byte address as seen by both requesters.
    typedef logic [31:0] word_t;    // Instruction or data word.
    typedef logic [7:0]  byte_t;    // One RAM byte.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte engine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A word moves through the engine as IDLE, ADDR (bytes 0 to 2), LAST (byte 3)
    // and DONE, which waits for the final read byte before reporting the word.
    typedef enum logic [1:0] {
        ENG_IDLE,   // Waiting for a queued request.
        ENG_ADDR,   // Issuing bytes 0, 1 and 2.
        ENG_LAST,   // Issuing byte 3.
        ENG_DONE    // Last byte in flight.
    } engine_state_t;

endpackage
